/* verilog/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Datapath widths
`define WORD_W       32
`define ADDR_W       32
`define WORD_BYTES   (`WORD_W / 8)
`define BYTE_OFF_W   $clog2(`WORD_BYTES)
`define REG_ADDR_W   5

// Cache geometry, direct mapped
`define LINE_WORDS    4
`define CACHE_LINES   16
`define WORD_IDX_W    $clog2(`LINE_WORDS)
`define LINE_OFF_W    (`WORD_IDX_W + `BYTE_OFF_W)
`define INDEX_W       $clog2(`CACHE_LINES)
`define TAG_W         (`ADDR_W - `INDEX_W - `LINE_OFF_W)

`endif

/* verilog/mem_types_pkg.sv */
`default_nettype none

`include "mem_consts.svh"

package mem_types_pkg;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_size_e;

    typedef struct packed {
        logic [`WORD_W-1:0]     a;
        logic [`WORD_W-1:0]     b;
        logic                   load;
        logic                   store;
        logic                   sign_ext;
        memop_size_e            size;
        logic                   rf_we;
        logic [`REG_ADDR_W-1:0] rf_waddr;
        logic [`WORD_W-1:0]     st_data;
    } mem_req_t;

    typedef struct packed {
        logic [`ADDR_W-1:0]     addr;
        logic                   load;
        logic                   store;
        logic                   sign_ext;
        memop_size_e            size;
        logic                   rf_we;
        logic [`REG_ADDR_W-1:0] rf_waddr;
        logic [`WORD_W-1:0]     st_data;
    } tl_stage_t;

    // Forwarded store-buffer bytes ride along with the op
    typedef struct packed {
        logic [`ADDR_W-1:0]     addr;
        logic                   load;
        logic                   store;
        logic                   sign_ext;
        memop_size_e            size;
        logic                   rf_we;
        logic [`REG_ADDR_W-1:0] rf_waddr;
        logic                   sb_match;
        logic [`WORD_BYTES-1:0] sb_mask;
        logic [`WORD_W-1:0]     sb_data;
    } mem_stage_t;

    typedef struct packed {
        logic                              valid;
        logic [`ADDR_W-`BYTE_OFF_W-1:0]    addr;
        logic [`WORD_BYTES-1:0]            mask;
        logic [`WORD_W-1:0]                data;
    } sb_entry_t;

    typedef logic [`LINE_WORDS-1:0][`WORD_W-1:0] line_t;

endpackage

`default_nettype wire

/* verilog/apb_pkg.sv */
`default_nettype none

`include "mem_consts.svh"

package apb_pkg;

    typedef struct packed {
        logic [`ADDR_W-1:0] paddr;
        logic               psel;
        logic               penable;
        logic               pwrite;
        logic [`WORD_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`WORD_W-1:0] prdata;
        logic               pready;
        logic               pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* verilog/store_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module store_buffer (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  mem_types_pkg::tl_stage_t  tl_i,
    input  logic                      write_i,
    input  logic                      miss_i,
    output logic                      match_o,
    output logic [`WORD_BYTES-1:0]    mask_o,
    output logic [`WORD_W-1:0]        data_o,
    output mem_types_pkg::sb_entry_t  drain_o
);
    import mem_types_pkg::*;

    sb_entry_t                       entry_q;
    logic [`ADDR_W-`BYTE_OFF_W-1:0]  word_addr;
    logic                            same_word;
    logic [`WORD_BYTES-1:0]          st_mask;
    logic [`WORD_W-1:0]              st_data;

    assign word_addr = tl_i.addr[`ADDR_W-1:`BYTE_OFF_W];
    assign same_word = entry_q.valid && (entry_q.addr == word_addr);

    assign match_o = tl_i.load && same_word;
    assign mask_o  = entry_q.mask;
    assign data_o  = entry_q.data;

    // Byte lanes touched by the store, data copied to every lane
    always_comb begin
        case (tl_i.size)
            BYTE: begin
                st_mask = 4'b0001 << tl_i.addr[`BYTE_OFF_W-1:0];
                st_data = {(`WORD_BYTES){tl_i.st_data[7:0]}};
            end
            HALF: begin
                st_mask = 4'b0011 << {tl_i.addr[1], 1'b0};
                st_data = {(`WORD_BYTES/2){tl_i.st_data[15:0]}};
            end
            default: begin
                st_mask = 4'b1111;
                st_data = tl_i.st_data;
            end
        endcase
    end

    // Write out on a store to another word, or before a refill
    always_comb begin
        drain_o       = entry_q;
        drain_o.valid = entry_q.valid && (miss_i || (write_i && !same_word));
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            entry_q.valid <= 1'b0;
        end else if (write_i) begin
            entry_q.valid <= 1'b1;
            entry_q.addr  <= word_addr;
            entry_q.mask  <= same_word ? (entry_q.mask | st_mask) : st_mask;
            for (int i = 0; i < `WORD_BYTES; i++) begin
                if (st_mask[i]) begin
                    entry_q.data[8*i +: 8] <= st_data[8*i +: 8];
                end
            end
        end else if (drain_o.valid) begin
            entry_q.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/tag_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module tag_lookup (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  mem_types_pkg::tl_stage_t   tl_i,
    input  logic                       sb_match_i,
    input  logic [`WORD_BYTES-1:0]     sb_mask_i,
    input  logic [`WORD_W-1:0]         sb_data_i,
    input  logic                       fill_i,
    output mem_types_pkg::mem_stage_t  mem_o,
    output logic                       miss_o,
    output logic [`TAG_W-1:0]          victim_tag_o,
    output logic                       victim_dirty_o,
    output logic [`ADDR_W-1:0]         refill_addr_o,
    output logic                       sb_write_o
);
    logic [`TAG_W-1:0]       tags_q [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;
    logic [`INDEX_W-1:0]     index;
    logic [`TAG_W-1:0]       tag;
    logic                    hit;

    assign index = tl_i.addr[`LINE_OFF_W +: `INDEX_W];
    assign tag   = tl_i.addr[`ADDR_W-1 -: `TAG_W];
    assign hit   = valid_q[index] && (tags_q[index] == tag);

    assign miss_o     = (tl_i.load || tl_i.store) && !hit;
    assign sb_write_o = tl_i.store && hit;

    assign victim_tag_o   = tags_q[index];
    assign victim_dirty_o = valid_q[index] && dirty_q[index];
    assign refill_addr_o  = {tl_i.addr[`ADDR_W-1:`LINE_OFF_W], {(`LINE_OFF_W){1'b0}}};

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tags_q[index] <= tag;
        end
    end

    // Refilled lines come in clean; a store hit marks the line dirty
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_i) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end else if (sb_write_o) begin
            dirty_q[index] <= 1'b1;
        end
    end

    // Bubble into MEM while the op waits for its line
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_o.load  <= 1'b0;
            mem_o.store <= 1'b0;
        end else begin
            mem_o <= '{addr: tl_i.addr, load: tl_i.load && !miss_o,
                       store: tl_i.store && !miss_o, sign_ext: tl_i.sign_ext,
                       size: tl_i.size, rf_we: tl_i.rf_we, rf_waddr: tl_i.rf_waddr,
                       sb_match: sb_match_i, sb_mask: sb_mask_i, sb_data: sb_data_i};
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_stage (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  mem_types_pkg::mem_stage_t  mem_i,
    input  mem_types_pkg::sb_entry_t   drain_i,
    input  logic                       fill_i,
    input  mem_types_pkg::line_t       fill_line_i,
    input  logic [`INDEX_W-1:0]        victim_index_i,
    output mem_types_pkg::line_t       victim_line_o,
    output logic                       valid_o,
    output logic                       rf_we_o,
    output logic [`REG_ADDR_W-1:0]     rf_waddr_o,
    output logic [`WORD_W-1:0]         data_o
);
    import mem_types_pkg::*;

    line_t                  lines_q [`CACHE_LINES];
    logic [`INDEX_W-1:0]    rd_index;
    logic [`WORD_IDX_W-1:0] rd_word;
    logic [`INDEX_W-1:0]    dr_index;
    logic [`WORD_IDX_W-1:0] dr_word;
    logic [`WORD_W-1:0]     cached;
    logic [`WORD_W-1:0]     merged;
    logic [`WORD_W-1:0]     shifted;
    logic [`WORD_W-1:0]     result;

    assign rd_index = mem_i.addr[`LINE_OFF_W +: `INDEX_W];
    assign rd_word  = mem_i.addr[`BYTE_OFF_W +: `WORD_IDX_W];
    assign cached   = lines_q[rd_index][rd_word];

    // Drain address is a word address
    assign dr_index = drain_i.addr[`WORD_IDX_W +: `INDEX_W];
    assign dr_word  = drain_i.addr[`WORD_IDX_W-1:0];

    assign victim_line_o = lines_q[victim_index_i];

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            lines_q[victim_index_i] <= fill_line_i;
        end else if (drain_i.valid) begin
            for (int i = 0; i < `WORD_BYTES; i++) begin
                if (drain_i.mask[i]) begin
                    lines_q[dr_index][dr_word][8*i +: 8] <= drain_i.data[8*i +: 8];
                end
            end
        end
    end

    // Pending store bytes win over the array
    always_comb begin
        for (int i = 0; i < `WORD_BYTES; i++) begin
            if (mem_i.sb_match && mem_i.sb_mask[i]) begin
                merged[8*i +: 8] = mem_i.sb_data[8*i +: 8];
            end else begin
                merged[8*i +: 8] = cached[8*i +: 8];
            end
        end
    end

    assign shifted = merged >> {mem_i.addr[`BYTE_OFF_W-1:0], 3'b000};

    always_comb begin
        case (mem_i.size)
            BYTE:    result = {{(`WORD_W-8){mem_i.sign_ext && shifted[7]}}, shifted[7:0]};
            HALF:    result = {{(`WORD_W-16){mem_i.sign_ext && shifted[15]}}, shifted[15:0]};
            default: result = merged;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            rf_we_o <= 1'b0;
        end else begin
            valid_o <= mem_i.load || mem_i.store;
            rf_we_o <= mem_i.load && mem_i.rf_we;
        end
    end

    always_ff @(posedge clk_i) begin
        rf_waddr_o <= mem_i.rf_waddr;
        data_o     <= result;
    end

endmodule

`default_nettype wire

/* verilog/apb_line_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module apb_line_master (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  miss_i,
    input  logic [`ADDR_W-1:0]    refill_addr_i,
    input  logic [`TAG_W-1:0]     victim_tag_i,
    input  logic                  victim_dirty_i,
    input  mem_types_pkg::line_t  victim_line_i,
    input  apb_pkg::apb_rsp_t     apb_rsp_i,
    output apb_pkg::apb_req_t     apb_req_o,
    output logic                  fill_o,
    output mem_types_pkg::line_t  fill_line_o
);
    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        FILL
    } state_e;

    state_e                 state_q;
    logic [`WORD_IDX_W-1:0] word_q;
    logic                   access_q;
    logic                   xfer_done;
    logic [`ADDR_W-1:0]     line_base;

    // Victim line shares the index, only the tag differs
    assign line_base = (state_q == WRITEBACK)
                     ? {victim_tag_i, refill_addr_i[`ADDR_W-`TAG_W-1:0]}
                     : refill_addr_i;

    assign xfer_done = access_q && apb_rsp_i.pready;
    assign fill_o    = (state_q == FILL);

    always_comb begin
        apb_req_o.psel    = (state_q == WRITEBACK) || (state_q == REFILL);
        apb_req_o.penable = access_q;
        apb_req_o.pwrite  = (state_q == WRITEBACK);
        apb_req_o.paddr   = {line_base[`ADDR_W-1:`LINE_OFF_W], word_q,
                             {(`BYTE_OFF_W){1'b0}}};
        apb_req_o.pwdata  = victim_line_i[word_q];
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= IDLE;
            word_q   <= '0;
            access_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (miss_i) begin
                        state_q <= victim_dirty_i ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK, REFILL: begin
                    if (!access_q) begin
                        access_q <= 1'b1;
                    end else if (xfer_done) begin
                        access_q <= 1'b0;
                        word_q   <= word_q + 1'b1;
                        // Last word of the line
                        if (&word_q) begin
                            state_q <= (state_q == WRITEBACK) ? REFILL : FILL;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == REFILL && xfer_done) begin
            fill_line_o[word_q] <= apb_rsp_i.prdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_pipeline (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     req_valid_i,
    input  mem_types_pkg::mem_req_t  req_i,
    input  apb_pkg::apb_rsp_t        apb_rsp_i,
    output logic                     stall_o,
    output logic                     valid_o,
    output logic                     rf_we_o,
    output logic [`WORD_W-1:0]       data_o,
    output logic [`REG_ADDR_W-1:0]   rf_waddr_o,
    output apb_pkg::apb_req_t        apb_req_o
);
    import mem_types_pkg::*;

    tl_stage_t              tl_q;
    mem_stage_t             mem_q;
    sb_entry_t              sb_drain;
    line_t                  victim_line;
    line_t                  fill_line;
    logic [`ADDR_W-1:0]     eff_addr;
    logic [`ADDR_W-1:0]     refill_addr;
    logic [`TAG_W-1:0]      victim_tag;
    logic                   victim_dirty;
    logic                   miss;
    logic                   fill;
    logic                   sb_write;
    logic                   sb_match;
    logic [`WORD_BYTES-1:0] sb_mask;
    logic [`WORD_W-1:0]     sb_data;

    assign eff_addr = $signed(req_i.a) + $signed(req_i.b);

    // Freeze the front end until the missing line is back
    assign stall_o = miss;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tl_q.load  <= 1'b0;
            tl_q.store <= 1'b0;
        end else if (!stall_o) begin
            tl_q <= '{addr: eff_addr, load: req_valid_i && req_i.load,
                      store: req_valid_i && req_i.store, sign_ext: req_i.sign_ext,
                      size: req_i.size, rf_we: req_i.rf_we, rf_waddr: req_i.rf_waddr,
                      st_data: req_i.st_data};
        end
    end

    tag_lookup u_tag_lookup (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .tl_i           (tl_q),
        .sb_match_i     (sb_match),
        .sb_mask_i      (sb_mask),
        .sb_data_i      (sb_data),
        .fill_i         (fill),
        .mem_o          (mem_q),
        .miss_o         (miss),
        .victim_tag_o   (victim_tag),
        .victim_dirty_o (victim_dirty),
        .refill_addr_o  (refill_addr),
        .sb_write_o     (sb_write)
    );

    store_buffer u_store_buffer (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .tl_i    (tl_q),
        .write_i (sb_write),
        .miss_i  (miss),
        .match_o (sb_match),
        .mask_o  (sb_mask),
        .data_o  (sb_data),
        .drain_o (sb_drain)
    );

    mem_stage u_mem_stage (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .mem_i          (mem_q),
        .drain_i        (sb_drain),
        .fill_i         (fill),
        .fill_line_i    (fill_line),
        .victim_index_i (refill_addr[`LINE_OFF_W +: `INDEX_W]),
        .victim_line_o  (victim_line),
        .valid_o        (valid_o),
        .rf_we_o        (rf_we_o),
        .rf_waddr_o     (rf_waddr_o),
        .data_o         (data_o)
    );

    apb_line_master u_apb_line_master (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .miss_i         (miss),
        .refill_addr_i  (refill_addr),
        .victim_tag_i   (victim_tag),
        .victim_dirty_i (victim_dirty),
        .victim_line_i  (victim_line),
        .apb_rsp_i      (apb_rsp_i),
        .apb_req_o      (apb_req_o),
        .fill_o         (fill),
        .fill_line_o    (fill_line)
    );

endmodule

`default_nettype wire

/* test/apb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module apb_mem_model #(
    parameter int MEM_WORDS   = 1024,
    parameter int WAIT_STATES = 2
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  apb_pkg::apb_req_t apb_req_i,
    output apb_pkg::apb_rsp_t apb_rsp_o
);
    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [`WORD_W-1:0] mem [MEM_WORDS];
    logic [IDX_W-1:0]   index;
    logic               access;
    logic [3:0]         wait_q;

    // Word index, upper address bits wrap
    assign index  = apb_req_i.paddr[`BYTE_OFF_W +: IDX_W];
    assign access = apb_req_i.psel && apb_req_i.penable;

    assign apb_rsp_o.pready  = access && (wait_q == WAIT_STATES);
    assign apb_rsp_o.prdata  = mem[index];
    assign apb_rsp_o.pslverr = 1'b0;

    // Counts access cycles of the current transfer
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wait_q <= '0;
        end else if (apb_rsp_o.pready) begin
            wait_q <= '0;
        end else if (access) begin
            wait_q <= wait_q + 1'b1;
        end
    end

    always @(posedge clk_i) begin
        if (apb_rsp_o.pready && apb_req_i.pwrite) begin
            mem[index] <= apb_req_i.pwdata;
        end
    end

endmodule

`default_nettype wire

/* test/tb_mem_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module tb_mem_pipeline;
    import mem_types_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int DRIVE_DLY      = 1;
    localparam int RESET_CYCLES   = 5;
    localparam int MEM_WORDS      = 1024;
    localparam int IDX_W          = $clog2(MEM_WORDS);
    localparam int RAND_REQS      = 200;
    localparam int DIRECTED_REQS  = 20;
    localparam int CYCLES_PER_REQ = 50;
    localparam int MARGIN         = 2;
    localparam int TIMEOUT_NS     = (RESET_CYCLES + (DIRECTED_REQS + RAND_REQS)
                                    * CYCLES_PER_REQ * MARGIN) * CLK_PERIOD;

    typedef struct packed {
        logic                   load;
        logic                   we;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`WORD_W-1:0]     data;
    } result_t;

    typedef struct packed {
        logic               write;
        logic [`ADDR_W-1:0] addr;
        logic [`WORD_W-1:0] data;
    } xfer_t;

    logic                   clk;
    logic                   reset;
    logic                   req_valid;
    mem_req_t               req;
    logic                   stall;
    logic                   valid;
    logic                   rf_we;
    logic [`WORD_W-1:0]     data;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    apb_pkg::apb_req_t      apb_req;
    apb_pkg::apb_rsp_t      apb_rsp;

    logic [31:0]        lfsr_q = 32'h6790_0b48;
    logic [`WORD_W-1:0] ref_mem [MEM_WORDS];
    result_t            exp_q[$];
    xfer_t              apb_log[$];
    int                 stall_cnt = 0;

    mem_pipeline UUT (
        .clk_i       (clk),
        .reset_i     (reset),
        .req_valid_i (req_valid),
        .req_i       (req),
        .apb_rsp_i   (apb_rsp),
        .stall_o     (stall),
        .valid_o     (valid),
        .rf_we_o     (rf_we),
        .data_o      (data),
        .rf_waddr_o  (rf_waddr),
        .apb_req_o   (apb_req)
    );

    apb_mem_model #(.MEM_WORDS(MEM_WORDS), .WAIT_STATES(2)) apb_slave (
        .clk_i     (clk),
        .reset_i   (reset),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic mem_req_t make_req(input logic is_store, input memop_size_e size,
                                          input logic sign, input logic [31:0] addr,
                                          input logic [4:0] waddr, input logic [31:0] wdata,
                                          input logic [31:0] b);
        mem_req_t r;
        r.a        = addr - b;
        r.b        = b;
        r.load     = !is_store;
        r.store    = is_store;
        r.sign_ext = sign;
        r.size     = size;
        r.rf_we    = !is_store;
        r.rf_waddr = waddr;
        r.st_data  = wdata;
        return r;
    endfunction

    // Sequential memory semantics with one result per accepted request
    task automatic apply_ref(input mem_req_t r);
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] val;
        int          idx;
        int          off;
        result_t     e;
        addr = r.a + r.b;
        idx  = addr[`BYTE_OFF_W +: IDX_W];
        off  = addr[`BYTE_OFF_W-1:0];
        word = ref_mem[idx];
        if (r.store) begin
            case (r.size)
                BYTE:    word[8*off +: 8] = r.st_data[7:0];
                HALF:    word[8*off +: 16] = r.st_data[15:0];
                default: word = r.st_data;
            endcase
            ref_mem[idx] = word;
        end
        val = word >> (8 * off);
        case (r.size)
            BYTE:    val = {{24{r.sign_ext && val[7]}}, val[7:0]};
            HALF:    val = {{16{r.sign_ext && val[15]}}, val[15:0]};
            default: val = word;
        endcase
        e.load  = r.load;
        e.we    = r.load && r.rf_we;
        e.waddr = r.rf_waddr;
        e.data  = val;
        exp_q.push_back(e);
    endtask

    task automatic issue(input mem_req_t r);
        logic taken;
        req       = r;
        req_valid = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !stall;
            @(posedge clk);
            #DRIVE_DLY;
        end
        req_valid = 1'b0;
        apply_ref(r);
    endtask

    task automatic do_load(input memop_size_e size, input logic sign,
                           input logic [31:0] addr, input logic [4:0] waddr);
        issue(make_req(1'b0, size, sign, addr, waddr, '0, 32'hFFFF_FFF0));
    endtask

    task automatic do_store(input memop_size_e size, input logic [31:0] addr,
                            input logic [31:0] wdata);
        issue(make_req(1'b1, size, 1'b0, addr, 5'd0, wdata, 32'h0000_0040));
    endtask

    task automatic wait_done();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic compare_result();
        result_t e;
        if (exp_q.size() == 0) begin
            $display("A result came out with no request outstanding");
            stop_run();
        end else begin
            e = exp_q.pop_front();
            check("rf_we_o", rf_we, e.we);
            check("rf_waddr_o", rf_waddr, e.waddr);
            if (e.load) begin
                check("data_o", data, e.data);
            end
        end
    endtask

    // Outputs and APB are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (stall) begin
                stall_cnt++;
            end
            if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
                apb_log.push_back('{write: apb_req.pwrite, addr: apb_req.paddr,
                                    data: apb_req.pwrite ? apb_req.pwdata : apb_rsp.prdata});
            end
            if (valid) begin
                compare_result();
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the pipeline stopped producing results");
        stop_run();
    end

    task automatic preload_memory();
        logic [31:0] v;
        for (int i = 0; i < MEM_WORDS; i++) begin
            take_bits(32, v);
            ref_mem[i] = v ^ i;
            apb_slave.mem[i] = ref_mem[i];
        end
    endtask

    task automatic test_reset_values();
        check("valid_o", valid, 1'b0);
        check("rf_we_o", rf_we, 1'b0);
        check("stall_o", stall, 1'b0);
        check("psel", apb_req.psel, 1'b0);
        check("penable", apb_req.penable, 1'b0);
    endtask

    task automatic test_miss_then_hit();
        int stalls_before;
        int xfers_before;
        stalls_before = stall_cnt;
        do_load(WORD, 1'b0, 32'h100, 5'd1);
        wait_done();
        check("stall_o seen", stall_cnt > stalls_before, 1'b1);
        xfers_before = apb_log.size();
        do_load(WORD, 1'b0, 32'h108, 5'd2);
        wait_done();
        check("APB transfers on hit", apb_log.size(), xfers_before);
    endtask

    task automatic test_forwarding();
        do_store(HALF, 32'h212, 32'h0000_8F3C);
        do_store(BYTE, 32'h211, 32'h0000_00A5);
        do_load(BYTE, 1'b1, 32'h211, 5'd3);
        do_load(BYTE, 1'b0, 32'h211, 5'd4);
        do_load(HALF, 1'b1, 32'h212, 5'd5);
        do_load(HALF, 1'b0, 32'h212, 5'd6);
        do_load(WORD, 1'b0, 32'h210, 5'd7);
        wait_done();
    endtask

    task automatic test_drain();
        do_store(WORD, 32'h320, 32'h1357_9BDF);
        do_store(WORD, 32'h324, 32'h2468_ACE0);
        do_store(BYTE, 32'h32B, 32'h0000_0077);
        do_load(WORD, 1'b0, 32'h320, 5'd8);
        do_load(WORD, 1'b0, 32'h324, 5'd9);
        wait_done();
    endtask

    // 0x430 and 0x530 share cache index 3
    task automatic test_writeback();
        xfer_t x;
        do_store(WORD, 32'h434, 32'hC0DE_1234);
        wait_done();
        apb_log.delete();
        do_load(WORD, 1'b0, 32'h534, 5'd10);
        wait_done();
        check("APB transfer count", apb_log.size(), 8);
        for (int i = 0; i < 8; i++) begin
            x = apb_log[i];
            check("pwrite", x.write, i < 4);
            check("paddr", x.addr, (i < 4 ? 32'h430 : 32'h530) + 4 * (i % 4));
            if (i < 4) begin
                check("pwdata", x.data, ref_mem[(32'h430 >> 2) + i]);
            end
        end
        do_load(WORD, 1'b0, 32'h434, 5'd11);
        wait_done();
    endtask

    task automatic test_random();
        logic [31:0] v;
        logic        is_store;
        logic        sign;
        memop_size_e size;
        logic [31:0] addr;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        for (int n = 0; n < RAND_REQS; n++) begin
            take_bits(1, v);
            is_store = v[0];
            take_bits(2, v);
            case (v[1:0])
                2'd0:    size = BYTE;
                2'd1:    size = HALF;
                default: size = WORD;
            endcase
            take_bits(1, v);
            sign = v[0];
            take_bits(10, v);
            addr = {22'h0, v[9:0]};
            if (size == HALF) begin
                addr[0] = 1'b0;
            end else if (size == WORD) begin
                addr[1:0] = 2'b00;
            end
            take_bits(5, v);
            waddr = v[4:0];
            take_bits(32, wdata);
            take_bits(32, v);
            issue(make_req(is_store, size, sign, addr, waddr, wdata, v));
        end
        wait_done();
    endtask

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        preload_memory();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        test_reset_values();
        test_miss_then_hit();
        test_forwarding();
        test_drain();
        test_writeback();
        test_random();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/mem_types_pkg.sv
verilog/apb_pkg.sv
verilog/store_buffer.sv
verilog/tag_lookup.sv
verilog/mem_stage.sv
verilog/apb_line_master.sv
verilog/mem_pipeline.sv
test/apb_mem_model.sv
test/tb_mem_pipeline.sv

/* Bender.yml */
package:
  name: mem_pipeline

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_types_pkg.sv
      - verilog/apb_pkg.sv
      - verilog/store_buffer.sv
      - verilog/tag_lookup.sv
      - verilog/mem_stage.sv
      - verilog/apb_line_master.sv
      - verilog/mem_pipeline.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/apb_mem_model.sv
      - test/tb_mem_pipeline.sv
